// File: include/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath width
`define EX_XLEN 32

// one shift-add per multiplier bit
`define EX_MUL_STEPS `EX_XLEN

// opcode field width
`define EX_OP_W 5

`endif

// File: source/ex_pkg.sv
`default_nettype none

`include "ex_config.svh"

package ex_pkg;

    typedef enum logic [`EX_OP_W-1:0] {
        op_auipc,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_lui,
        op_bge,
        op_bgeu,
        op_blt,
        op_bltu,
        op_bne,
        op_beq,
        op_mul,
        op_mulhu
    } alu_op_e;

    typedef enum logic [1:0] {
        idle,
        mul_run,
        mul_done
    } ex_state_e;

    function automatic logic is_branch(alu_op_e op);
        return op inside {op_bge, op_bgeu, op_blt, op_bltu, op_bne, op_beq};
    endfunction

    function automatic logic is_mul(alu_op_e op);
        return op inside {op_mul, op_mulhu};
    endfunction

endpackage

`default_nettype wire

// File: source/mul_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mul_ctrl_if;

    logic load;      // preset counter, capture operands
    logic step;      // one shift-add
    logic last;      // counter at zero
    logic high_sel;  // mulhu selects upper word

    modport control (
        output load,
        output step,
        output high_sel,
        input  last
    );

    modport counter (
        input  load,
        input  step,
        output last
    );

    modport mul (
        input load,
        input step,
        input high_sel
    );

endinterface

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module alu (
    input  wire [`EX_XLEN-1:0] op1,
    input  wire [`EX_XLEN-1:0] op2,
    input  wire ex_pkg::alu_op_e alu_op,
    output logic [`EX_XLEN-1:0] result,
    output logic zero,
    output logic c_out,
    output logic overflow
);

    localparam int MSB   = `EX_XLEN - 1;
    localparam int SHW   = $clog2(`EX_XLEN);

    logic [SHW-1:0]    shamt;
    logic [`EX_XLEN:0] sll_ext;  // top bit is last bit out
    logic [`EX_XLEN:0] srl_ext;  // bit 0 is last bit out
    logic [`EX_XLEN:0] sra_ext;
    logic              lt_s;
    logic              lt_u;

    assign shamt = op2[SHW-1:0];

    // one guard bit on the exit side, zero for a shift of zero
    assign sll_ext = {1'b0, op1} << shamt;
    assign srl_ext = {op1, 1'b0} >> shamt;
    assign sra_ext = $signed({op1, 1'b0}) >>> shamt;

    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb
    begin
        result   = '0;
        c_out    = 1'b0;
        overflow = 1'b0;

        case (alu_op)
            ex_pkg::op_auipc,
            ex_pkg::op_add:
            begin
                result   = op1 + op2;
                overflow = (op1[MSB] == op2[MSB]) && (result[MSB] != op1[MSB]);
            end
            ex_pkg::op_sub:
            begin
                result   = op1 - op2;
                overflow = (op1[MSB] != op2[MSB]) && (result[MSB] != op1[MSB]);
            end
            ex_pkg::op_and:
            begin
                result = op1 & op2;
            end
            ex_pkg::op_or:
            begin
                result = op1 | op2;
            end
            ex_pkg::op_xor:
            begin
                result = op1 ^ op2;
            end
            ex_pkg::op_sll:
            begin
                result = sll_ext[MSB:0];
                c_out  = sll_ext[`EX_XLEN];
            end
            ex_pkg::op_srl:
            begin
                result = srl_ext[`EX_XLEN:1];
                c_out  = srl_ext[0];
            end
            ex_pkg::op_sra:
            begin
                result = sra_ext[`EX_XLEN:1];
                c_out  = sra_ext[0];
            end
            ex_pkg::op_slt:
            begin
                result[0] = lt_s;
                c_out     = lt_s;  // compares report the flag on carry too
            end
            ex_pkg::op_sltu:
            begin
                result[0] = lt_u;
                c_out     = lt_u;
            end
            ex_pkg::op_lui:
            begin
                result = op1;  // immediate already shifted by decode
            end
            ex_pkg::op_bge:
            begin
                result[0] = !lt_s;
            end
            ex_pkg::op_bgeu:
            begin
                result[0] = !lt_u;
            end
            ex_pkg::op_blt:
            begin
                result[0] = lt_s;
            end
            ex_pkg::op_bltu:
            begin
                result[0] = lt_u;
            end
            ex_pkg::op_bne:
            begin
                result[0] = (op1 != op2);
            end
            ex_pkg::op_beq:
            begin
                result[0] = (op1 == op2);
            end
            default:
            begin
                result = '0;  // multiplies handled elsewhere
            end
        endcase

        zero = (result == '0);  // inverse of bit 0 for compares
    end

endmodule

`default_nettype wire

// File: source/ex_control.sv
`timescale 1ns/1ps
`default_nettype none

module ex_control (
    input  wire clk_in,
    input  wire arst_n,
    input  wire rdy_in,
    input  wire issue,
    input  wire ex_pkg::alu_op_e alu_op,
    mul_ctrl_if.control ctrl,
    output logic busy,
    output logic capture
);

    ex_pkg::ex_state_e state;
    ex_pkg::ex_state_e state_nxt;
    logic              accept;
    logic              mul_issue;
    logic              high_sel_q;

    assign accept    = issue && rdy_in && (state == ex_pkg::idle);
    assign mul_issue = accept && ex_pkg::is_mul(alu_op);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ex_pkg::idle:
            begin
                if (mul_issue)
                    state_nxt = ex_pkg::mul_run;
            end
            ex_pkg::mul_run:
            begin
                if (ctrl.last)
                    state_nxt = ex_pkg::mul_done;
            end
            ex_pkg::mul_done:
            begin
                state_nxt = ex_pkg::idle;
            end
            default:
            begin
                state_nxt = ex_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= ex_pkg::idle;
            high_sel_q <= 1'b0;
        end
        else if (rdy_in)
        begin
            state <= state_nxt;
            if (mul_issue)
                high_sel_q <= (alu_op == ex_pkg::op_mulhu);
        end
    end

    assign ctrl.load     = mul_issue;
    assign ctrl.step     = rdy_in && (state == ex_pkg::mul_run);
    assign ctrl.high_sel = high_sel_q;

    // alu ops finish in the issue cycle, multiplies in mul_done
    assign capture = (accept && !ex_pkg::is_mul(alu_op))
                  || (rdy_in && (state == ex_pkg::mul_done));
    assign busy    = (state != ex_pkg::idle);

endmodule

`default_nettype wire

// File: source/iter_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module iter_counter (
    input  wire clk_in,
    input  wire arst_n,
    input  wire rdy_in,
    mul_ctrl_if.counter ctrl
);

    localparam int CNT_W = $clog2(`EX_MUL_STEPS);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (rdy_in)
        begin
            if (ctrl.load)
                count <= CNT_W'(`EX_MUL_STEPS - 1);
            else if (ctrl.step && (count != '0))
                count <= count - 1'b1;  // holds at zero
        end
    end

    assign ctrl.last = (count == '0);

endmodule

`default_nettype wire

// File: source/shift_add_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module shift_add_mul (
    input  wire clk_in,
    input  wire arst_n,
    input  wire rdy_in,
    input  wire [`EX_XLEN-1:0] op1,
    input  wire [`EX_XLEN-1:0] op2,
    mul_ctrl_if.mul ctrl,
    output logic [`EX_XLEN-1:0] product_sel
);

    localparam int XL = `EX_XLEN;

    logic [XL-1:0]   mcand;
    logic [2*XL-1:0] acc;  // low half starts as the multiplier
    logic [XL:0]     sum;

    // add multiplicand into upper half when the current multiplier bit is set
    assign sum = {1'b0, acc[2*XL-1:XL]} + (acc[0] ? {1'b0, mcand} : {(XL+1){1'b0}});

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mcand <= '0;
            acc   <= '0;
        end
        else if (rdy_in)
        begin
            if (ctrl.load)
            begin
                mcand <= op1;
                acc   <= {{XL{1'b0}}, op2};
            end
            else if (ctrl.step)
                acc <= {sum, acc[XL-1:1]};  // carry shifts into the top
        end
    end

    assign product_sel = ctrl.high_sel ? acc[2*XL-1:XL] : acc[XL-1:0];

endmodule

`default_nettype wire

// File: source/ex_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_result_reg (
    input  wire clk_in,
    input  wire arst_n,
    input  wire rdy_in,
    input  wire capture,
    input  wire ex_pkg::alu_op_e alu_op,
    input  wire [`EX_XLEN-1:0] pc,
    input  wire [`EX_XLEN-1:0] imm,
    input  wire [`EX_XLEN-1:0] alu_result,
    input  wire alu_zero,
    input  wire alu_c_out,
    input  wire alu_overflow,
    input  wire [`EX_XLEN-1:0] product_sel,
    input  wire mul_pending,
    output logic [`EX_XLEN-1:0] result,
    output logic zero,
    output logic c_out,
    output logic overflow,
    output logic branch_taken,
    output logic [`EX_XLEN-1:0] branch_target,
    output logic out_valid
);

    ex_pkg::alu_op_e     op_q;
    logic [`EX_XLEN-1:0] pc_q;
    logic [`EX_XLEN-1:0] imm_q;
    ex_pkg::alu_op_e     op_sel;
    logic [`EX_XLEN-1:0] pc_sel;
    logic [`EX_XLEN-1:0] imm_sel;

    // tracks the inputs while idle, holds them through a multiply
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && !mul_pending)
        begin
            op_q  <= alu_op;
            pc_q  <= pc;
            imm_q <= imm;
        end
    end

    assign op_sel  = mul_pending ? op_q  : alu_op;
    assign pc_sel  = mul_pending ? pc_q  : pc;
    assign imm_sel = mul_pending ? imm_q : imm;

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            result        <= '0;
            zero          <= 1'b0;
            c_out         <= 1'b0;
            overflow      <= 1'b0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
            out_valid     <= 1'b0;
        end
        else
        begin
            out_valid <= rdy_in && capture;  // single pulse even if paused next
            if (rdy_in && capture)
            begin
                if (ex_pkg::is_mul(op_sel))
                begin
                    result       <= product_sel;
                    zero         <= (product_sel == '0);
                    c_out        <= 1'b0;
                    overflow     <= 1'b0;
                    branch_taken <= 1'b0;
                end
                else
                begin
                    result       <= alu_result;
                    zero         <= alu_zero;
                    c_out        <= alu_c_out;
                    overflow     <= alu_overflow;
                    branch_taken <= ex_pkg::is_branch(op_sel) && alu_result[0];
                end
                branch_target <= pc_sel + imm_sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_unit (
    input  wire clk_in,
    input  wire arst_n,
    input  wire rdy_in,
    input  wire issue,
    input  wire ex_pkg::alu_op_e alu_op,
    input  wire [`EX_XLEN-1:0] op1,
    input  wire [`EX_XLEN-1:0] op2,
    input  wire [`EX_XLEN-1:0] pc,
    input  wire [`EX_XLEN-1:0] imm,
    output logic [`EX_XLEN-1:0] result,
    output logic zero,
    output logic c_out,
    output logic overflow,
    output logic branch_taken,
    output logic [`EX_XLEN-1:0] branch_target,
    output logic out_valid,
    output logic busy
);

    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic                alu_c_out;
    logic                alu_overflow;
    logic [`EX_XLEN-1:0] product_sel;
    logic                capture;

    mul_ctrl_if mul_ctrl ();

    alu alu_i (
        .op1      (op1),
        .op2      (op2),
        .alu_op   (alu_op),
        .result   (alu_result),
        .zero     (alu_zero),
        .c_out    (alu_c_out),
        .overflow (alu_overflow)
    );

    ex_control ex_control_i (
        .clk_in  (clk_in),
        .arst_n  (arst_n),
        .rdy_in  (rdy_in),
        .issue   (issue),
        .alu_op  (alu_op),
        .ctrl    (mul_ctrl.control),
        .busy    (busy),
        .capture (capture)
    );

    iter_counter iter_counter_i (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .rdy_in (rdy_in),
        .ctrl   (mul_ctrl.counter)
    );

    shift_add_mul shift_add_mul_i (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .rdy_in      (rdy_in),
        .op1         (op1),
        .op2         (op2),
        .ctrl        (mul_ctrl.mul),
        .product_sel (product_sel)
    );

    ex_result_reg ex_result_reg_i (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .rdy_in        (rdy_in),
        .capture       (capture),
        .alu_op        (alu_op),
        .pc            (pc),
        .imm           (imm),
        .alu_result    (alu_result),
        .alu_zero      (alu_zero),
        .alu_c_out     (alu_c_out),
        .alu_overflow  (alu_overflow),
        .product_sel   (product_sel),
        .mul_pending   (busy),
        .result        (result),
        .zero          (zero),
        .c_out         (c_out),
        .overflow      (overflow),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

// File: testbench/ex_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit_properties (
    input wire clk_in,
    input wire arst_n,
    input wire rdy_in,
    input wire issue,
    input wire ex_pkg::alu_op_e alu_op,
    input wire out_valid,
    input wire busy
);

    logic alu_issue;

    assign alu_issue = issue && rdy_in && !busy
                    && (alu_op != ex_pkg::op_mul) && (alu_op != ex_pkg::op_mulhu);

    out_valid_pulse: assert property (@(posedge clk_in) disable iff (!arst_n)
        out_valid |=> !out_valid)
        else $error("out_valid high on two consecutive cycles");

    busy_after_reset: assert property (@(posedge clk_in) $rose(arst_n) |-> !busy)
        else $error("busy high right after reset release");

    // single-cycle ops answer on the next edge
    alu_latency: assert property (@(posedge clk_in) disable iff (!arst_n)
        alu_issue |=> out_valid)
        else $error("out_valid missing one cycle after an ALU issue");

endmodule

`default_nettype wire

// File: testbench/ex_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit_tb;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [31:0] result;
        logic        zero;
        logic        c_out;
        logic        overflow;
        logic        taken;
        logic [31:0] target;
    } exp_t;

    logic            clk_in;
    logic            arst_n;
    logic            rdy_in;
    logic            issue;
    ex_pkg::alu_op_e alu_op;
    logic [31:0]     op1;
    logic [31:0]     op2;
    logic [31:0]     pc;
    logic [31:0]     imm;
    logic [31:0]     result;
    logic            zero;
    logic            c_out;
    logic            overflow;
    logic            branch_taken;
    logic [31:0]     branch_target;
    logic            out_valid;
    logic            busy;

    exp_t        exp_q[$];
    logic [31:0] lfsr = 32'h1f33;
    logic        pause_en = 1'b0;
    int          errors = 0;
    int          checks = 0;

    ex_unit dut_i (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .rdy_in        (rdy_in),
        .issue         (issue),
        .alu_op        (alu_op),
        .op1           (op1),
        .op2           (op2),
        .pc            (pc),
        .imm           (imm),
        .result        (result),
        .zero          (zero),
        .c_out         (c_out),
        .overflow      (overflow),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .out_valid     (out_valid),
        .busy          (busy)
    );

    bind ex_unit ex_unit_properties props_i (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rdy_in    (rdy_in),
        .issue     (issue),
        .alu_op    (alu_op),
        .out_valid (out_valid),
        .busy      (busy)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic exp_t ref_exec(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b, input logic [31:0] pc_v,
                                      input logic [31:0] imm_v);
        exp_t        e;
        logic [5:0]  sh;
        logic [63:0] prod;
        logic [31:0] out_bits;
        logic        lt_s;
        logic        lt_u;
        logic        br;
        e = '0;
        sh = {1'b0, b[4:0]};
        prod = {32'd0, a} * {32'd0, b};
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        br = op inside {ex_pkg::op_bge, ex_pkg::op_bgeu, ex_pkg::op_blt,
                        ex_pkg::op_bltu, ex_pkg::op_bne, ex_pkg::op_beq};
        case (op)
            ex_pkg::op_auipc,
            ex_pkg::op_add:
            begin
                e.result = a + b;
                e.overflow = (longint'($signed(a)) + longint'($signed(b)))
                          != longint'($signed(e.result));  // true sum does not fit
            end
            ex_pkg::op_sub:
            begin
                e.result = a - b;
                e.overflow = (longint'($signed(a)) - longint'($signed(b)))
                          != longint'($signed(e.result));
            end
            ex_pkg::op_and:   e.result = a & b;
            ex_pkg::op_or:    e.result = a | b;
            ex_pkg::op_xor:   e.result = a ^ b;
            ex_pkg::op_sll:
            begin
                e.result = a << sh;
                out_bits = a >> (6'd32 - sh);  // bit 32-sh of op1
                e.c_out = (sh != 6'd0) && out_bits[0];
            end
            ex_pkg::op_srl,
            ex_pkg::op_sra:
            begin
                if (op == ex_pkg::op_sra)
                    e.result = $signed(a) >>> sh;
                else
                    e.result = a >> sh;
                out_bits = a >> (sh - 6'd1);  // bit sh-1 of op1
                e.c_out = (sh != 6'd0) && out_bits[0];
            end
            ex_pkg::op_slt:
            begin
                e.result = {31'd0, lt_s};
                e.c_out = lt_s;
            end
            ex_pkg::op_sltu:
            begin
                e.result = {31'd0, lt_u};
                e.c_out = lt_u;
            end
            ex_pkg::op_lui:   e.result = a;
            ex_pkg::op_bge:   e.result = {31'd0, !lt_s};
            ex_pkg::op_bgeu:  e.result = {31'd0, !lt_u};
            ex_pkg::op_blt:   e.result = {31'd0, lt_s};
            ex_pkg::op_bltu:  e.result = {31'd0, lt_u};
            ex_pkg::op_bne:   e.result = {31'd0, a != b};
            ex_pkg::op_beq:   e.result = {31'd0, a == b};
            ex_pkg::op_mul:   e.result = prod[31:0];
            ex_pkg::op_mulhu: e.result = prod[63:32];
            default:          e.result = '0;
        endcase
        e.zero = (e.result == 32'd0);
        e.taken = br && e.result[0];
        e.target = pc_v + imm_v;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic timeout_exit(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic run_op(input ex_pkg::alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic measure);
        logic [31:0] pc_v;
        logic [31:0] imm_v;
        logic        mul_op;
        logic        accepted;
        logic        done;
        int          n;
        pc_v = rand_bits(32) & 32'hffff_fffc;
        imm_v = rand_bits(32);
        mul_op = (op == ex_pkg::op_mul) || (op == ex_pkg::op_mulhu);
        exp_q.push_back(ref_exec(op, a, b, pc_v, imm_v));
        @(posedge clk_in);
        issue  <= 1'b1;
        alu_op <= op;
        op1    <= a;
        op2    <= b;
        pc     <= pc_v;
        imm    <= imm_v;
        n = 0;
        @(posedge clk_in);
        accepted = rdy_in;  // value the DUT samples on this edge
        while (!accepted && n < WAIT_LIMIT)
        begin
            @(posedge clk_in);
            accepted = rdy_in;
            n++;
        end
        if (!accepted)
            timeout_exit("issue to be accepted");
        else
        begin
            issue <= 1'b0;
            n = 0;
            done = 1'b0;
            while (!done && n < WAIT_LIMIT)
            begin
                @(negedge clk_in);
                n++;
                done = out_valid;
                if (measure)
                    check("busy", 32'(busy), 32'(mul_op && !done));
            end
            if (!done)
                timeout_exit("out_valid");
            else if (measure)
                check("latency", 32'(n), mul_op ? 32'd34 : 32'd1);
        end
    endtask

    // compares every result strobe with the oldest expected item
    initial
    begin
        exp_t e;
        forever
        begin
            @(negedge clk_in);
            if (arst_n && out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("out_valid at %0t with no operation outstanding", $time);
                end
                else
                begin
                    e = exp_q.pop_front();
                    check("result", result, e.result);
                    check("zero", 32'(zero), 32'(e.zero));
                    check("c_out", 32'(c_out), 32'(e.c_out));
                    check("overflow", 32'(overflow), 32'(e.overflow));
                    check("branch_taken", 32'(branch_taken), 32'(e.taken));
                    check("branch_target", branch_target, e.target);
                end
            end
        end
    end

    initial
    begin
        logic [31:0] ps;
        ps = 32'h1f33;
        rdy_in <= 1'b1;
        forever
        begin
            @(posedge clk_in);
            if (pause_en)
            begin
                ps = lfsr_next(lfsr_next(ps));
                rdy_in <= (ps[1:0] != 2'b00);  // roughly one cycle in four paused
            end
            else
                rdy_in <= 1'b1;
        end
    end

    initial
    begin
        logic [31:0]     a;
        logic [31:0]     b;
        ex_pkg::alu_op_e op;
        int              steps;
        issue  <= 1'b0;
        alu_op <= ex_pkg::op_add;
        op1    <= '0;
        op2    <= '0;
        pc     <= '0;
        imm    <= '0;
        arst_n <= 1'b0;
        repeat (5) @(posedge clk_in);
        arst_n <= 1'b1;
        @(negedge clk_in);
        check("result", result, 32'd0);
        check("branch_target", branch_target, 32'd0);
        check("flags", 32'({zero, c_out, overflow, branch_taken}), 32'd0);
        check("out_valid", 32'(out_valid), 32'd0);
        check("busy", 32'(busy), 32'd0);

        run_op(ex_pkg::op_add, 32'h7fff_ffff, 32'd1, 1'b1);
        run_op(ex_pkg::op_add, 32'h8000_0000, 32'h8000_0000, 1'b1);
        run_op(ex_pkg::op_sub, 32'h8000_0000, 32'd1, 1'b1);
        run_op(ex_pkg::op_sub, 32'd0, 32'h8000_0000, 1'b1);
        run_op(ex_pkg::op_auipc, 32'hffff_f000, 32'h0000_1000, 1'b1);
        for (int k = 0; k < 8; k++)
        begin
            run_op(ex_pkg::op_add, rand_bits(32), rand_bits(32), 1'b1);
            run_op(ex_pkg::op_sub, rand_bits(32), rand_bits(32), 1'b1);
            run_op(ex_pkg::op_auipc, rand_bits(32), rand_bits(32), 1'b1);
        end

        run_op(ex_pkg::op_and, 32'h0f0f_0f0f, 32'hf0f0_f0f0, 1'b1);
        for (int k = 0; k < 6; k++)
        begin
            run_op(ex_pkg::op_and, rand_bits(32), rand_bits(32), 1'b1);
            run_op(ex_pkg::op_or, rand_bits(32), rand_bits(32), 1'b1);
            run_op(ex_pkg::op_xor, rand_bits(32), rand_bits(32), 1'b1);
            run_op(ex_pkg::op_lui, rand_bits(20) << 12, 32'd0, 1'b1);
        end
        for (int k = 0; k < 8; k++)
        begin
            a = rand_bits(32);
            b = rand_bits(32);
            b[4:0] = (k == 0) ? 5'd0 : (k == 1) ? 5'd1 : (k == 2) ? 5'd31 : b[4:0];
            run_op(ex_pkg::op_sll, a, b, 1'b1);
            run_op(ex_pkg::op_srl, a, b, 1'b1);
            run_op(ex_pkg::op_sra, a, b, 1'b1);
        end

        // slt through beq, lui sits in between
        op = ex_pkg::op_slt;
        for (int k = 0; k < 9; k++)
        begin
            if (op != ex_pkg::op_lui)
            begin
                a = rand_bits(32);
                run_op(op, a, a, 1'b1);
                run_op(op, 32'h8000_0000, 32'h7fff_ffff, 1'b1);
                run_op(op, rand_bits(32), rand_bits(32), 1'b1);
                run_op(op, rand_bits(32), rand_bits(32), 1'b1);
            end
            op = op.next();
        end

        for (int k = 0; k < 2; k++)
        begin
            op = (k == 0) ? ex_pkg::op_mul : ex_pkg::op_mulhu;
            run_op(op, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
            run_op(op, 32'd0, rand_bits(32), 1'b1);
            run_op(op, 32'h8000_0000, 32'd2, 1'b1);
            run_op(op, 32'd1, rand_bits(32), 1'b1);
            repeat (4) run_op(op, rand_bits(32), rand_bits(32), 1'b1);
        end

        pause_en = 1'b1;
        run_op(ex_pkg::op_mul, rand_bits(32), rand_bits(32), 1'b0);
        run_op(ex_pkg::op_mulhu, rand_bits(32), rand_bits(32), 1'b0);
        for (int k = 0; k < 24; k++)
        begin
            steps = int'(rand_bits(5) % 32'd20);
            op = op.first();
            repeat (steps) op = op.next();
            run_op(op, rand_bits(32), rand_bits(32), 1'b0);
        end
        pause_en = 1'b0;

        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected results were never produced", exp_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
source/ex_pkg.sv
source/mul_ctrl_if.sv
source/alu.sv
source/ex_control.sv
source/iter_counter.sv
source/shift_add_mul.sv
source/ex_result_reg.sv
source/ex_unit.sv
testbench/ex_unit_properties.sv
testbench/ex_unit_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -f filelist.f --top-module ex_unit_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vex_unit_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
